//--- rtl/llc_tag_pkg.sv
// Shared definitions of the LLC tag store
// Request operation modes and the tag macro read latency
package llc_tag_pkg;

  // Operation carried by a tag store request
  // Lookup searches a set and installs on a miss
  // Flush clears one named way of a set
  // Bist runs the self test over all ways
  typedef enum logic [1:0] {
    Lookup = 2'd0,
    Flush  = 2'd1,
    Bist   = 2'd2
  } mode_e;

  // Read latency of a tag macro in cycles
  // Read data and its valid token come out this many edges after the read
  localparam int unsigned TagMacroLatency = 1;

endpackage

//--- rtl/llc_tag_sram.sv
// Tag memory of one way
// Single port array with registered read data and a read-valid token
`timescale 1ns/1ps

module llc_tag_sram #(
  parameter int unsigned NumLines = 16,
  parameter int unsigned TagWidth = 8,
  localparam int unsigned IdxW = (NumLines > 1) ? $clog2(NumLines) : 1
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [IdxW-1:0]     index_i,
  input  logic [TagWidth+1:0] wdata_i,
  output logic [TagWidth+1:0] rdata_o,
  output logic                rvalid_o
);

  localparam int unsigned Lat = llc_tag_pkg::TagMacroLatency;

  // Entry is valid, dirty, tag from the top
  logic [TagWidth+1:0]          mem_q [NumLines];
  logic [Lat-1:0][TagWidth+1:0] rdata_q;
  logic [Lat-1:0]               token_q;
  logic                         rd;

  assign rd = req_i & ~we_i;

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[index_i] <= wdata_i;
    end
  end

  // Data stages only move with their token, so read data holds between reads
  always_ff @(posedge clk_i) begin
    if (rd) begin
      rdata_q[0] <= mem_q[index_i];
    end
    for (int s = 1; s < Lat; s++) begin
      if (token_q[s-1]) begin
        rdata_q[s] <= rdata_q[s-1];
      end
    end
  end

  // One token per read, marks the data at the last stage
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      token_q <= '0;
    end else begin
      token_q[0] <= rd;
      for (int s = 1; s < Lat; s++) begin
        token_q[s] <= token_q[s-1];
      end
    end
  end

  assign rdata_o  = rdata_q[Lat-1];
  assign rvalid_o = token_q[Lat-1];

endmodule

//--- rtl/llc_tag_pattern_gen.sv
// BIST sequencer for the tag memories
// Writes a pattern, reads it back, clears all lines and collects per-way fail bits
`timescale 1ns/1ps

module llc_tag_pattern_gen #(
  parameter int unsigned NumWays  = 4,
  parameter int unsigned NumLines = 16,
  parameter int unsigned TagWidth = 8,
  localparam int unsigned IdxW = (NumLines > 1) ? $clog2(NumLines) : 1
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  logic                rvalid_i,
  input  logic [NumWays-1:0]  fail_i,
  output logic                busy_o,
  output logic                req_o,
  output logic                we_o,
  output logic [IdxW-1:0]     index_o,
  output logic [TagWidth+1:0] pattern_o,
  output logic [NumWays-1:0]  bist_res_o,
  output logic                eoc_o
);

  localparam int unsigned Lat = llc_tag_pkg::TagMacroLatency;

  // Phases of the test
  localparam logic [2:0] PhIdle  = 3'd0;
  localparam logic [2:0] PhWrite = 3'd1;
  localparam logic [2:0] PhRead  = 3'd2;
  localparam logic [2:0] PhDrain = 3'd3;
  localparam logic [2:0] PhClear = 3'd4;

  logic [2:0]                   phase_q, phase_d;
  logic [IdxW-1:0]              idx_q, idx_d;
  logic                         last;
  logic                         eoc_q, eoc_d;
  logic [TagWidth-1:0]          pat_tag;
  logic [TagWidth+1:0]          wr_pattern;
  logic [Lat-1:0][TagWidth+1:0] exp_q;
  logic [NumWays-1:0]           fail_q;

  // Index bits repeated over the tag, inverted on odd lines
  always_comb begin
    for (int b = 0; b < TagWidth; b++) begin
      pat_tag[b] = idx_q[b % IdxW];
    end
    if (idx_q[0]) begin
      pat_tag = ~pat_tag;
    end
  end
  assign wr_pattern = {2'b11, pat_tag};

  assign last = (idx_q == IdxW'(NumLines - 1));

  always_comb begin
    phase_d = phase_q;
    idx_d   = idx_q + 1'b1;
    eoc_d   = 1'b0;
    case (phase_q)
      PhIdle: begin
        idx_d = '0;
        if (start_i) begin
          phase_d = PhWrite;
        end
      end
      PhWrite: begin
        if (last) begin
          phase_d = PhRead;
          idx_d   = '0;
        end
      end
      PhRead: begin
        if (last) begin
          phase_d = PhDrain;
          idx_d   = '0;
        end
      end
      // Wait for the last read data before the clear pass
      PhDrain: begin
        if (idx_q == IdxW'(Lat - 1)) begin
          phase_d = PhClear;
          idx_d   = '0;
        end
      end
      PhClear: begin
        if (last) begin
          phase_d = PhIdle;
          idx_d   = '0;
          eoc_d   = 1'b1;
        end
      end
      default: begin
        phase_d = PhIdle;
        idx_d   = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= PhIdle;
      idx_q   <= '0;
      eoc_q   <= 1'b0;
      fail_q  <= '0;
    end else begin
      phase_q <= phase_d;
      idx_q   <= idx_d;
      eoc_q   <= eoc_d;
      // Sticky fail bits, cleared when a new test starts
      if (start_i && (phase_q == PhIdle)) begin
        fail_q <= '0;
      end else if (rvalid_i) begin
        fail_q <= fail_q | fail_i;
      end
    end
  end

  // Expected pattern lined up with the read data
  always_ff @(posedge clk_i) begin
    exp_q[0] <= wr_pattern;
    for (int s = 1; s < Lat; s++) begin
      exp_q[s] <= exp_q[s-1];
    end
  end

  assign busy_o    = (phase_q != PhIdle);
  assign req_o     = (phase_q == PhWrite) | (phase_q == PhRead) | (phase_q == PhClear);
  assign we_o      = (phase_q == PhWrite) | (phase_q == PhClear);
  assign index_o   = idx_q;
  // Write data in write pass, expectation during read back, zeros when clearing
  assign pattern_o = (phase_q == PhWrite) ? wr_pattern :
                     ((phase_q == PhRead) || (phase_q == PhDrain)) ? exp_q[Lat-1] : '0;
  assign bist_res_o = fail_q;
  assign eoc_o      = eoc_q;

endmodule

//--- rtl/llc_evict_box.sv
// Victim way selection for a lookup miss
// Free ways first, then round robin over the unlocked ways
`timescale 1ns/1ps

module llc_evict_box #(
  parameter int unsigned NumWays = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               req_i,
  input  logic [NumWays-1:0] tag_valid_i,
  input  logic [NumWays-1:0] tag_dirty_i,
  input  logic [NumWays-1:0] spm_lock_i,
  output logic [NumWays-1:0] way_o,
  output logic               evict_o,
  output logic               valid_o
);

  localparam int unsigned PtrW = (NumWays > 1) ? $clog2(NumWays) : 1;

  logic [PtrW-1:0]    ptr_q, ptr_d;
  logic [NumWays-1:0] free;
  logic [NumWays-1:0] victim;
  logic [NumWays-1:0] way_q;
  logic               evict_q;
  logic               valid_q;

  always_comb begin
    int unsigned j;
    logic        found;
    j      = 0;
    found  = 1'b0;
    victim = '0;
    ptr_d  = ptr_q;
    free   = ~tag_valid_i & ~spm_lock_i;
    if (|free) begin
      // Lowest empty unlocked way, pointer untouched
      for (int i = 0; i < NumWays; i++) begin
        if (free[i] && !found) begin
          victim[i] = 1'b1;
          found     = 1'b1;
        end
      end
    end else begin
      // Set is full, walk cyclically from the pointer
      for (int k = 0; k < NumWays; k++) begin
        j = (int'(ptr_q) + k) % NumWays;
        if (!spm_lock_i[j] && !found) begin
          victim[j] = 1'b1;
          found     = 1'b1;
          ptr_d     = PtrW'((j + 1) % NumWays);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i;
      if (req_i) begin
        ptr_q <= ptr_d;
      end
    end
  end

  // Choice holds until the next request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      way_q   <= victim;
      evict_q <= |(victim & tag_valid_i & tag_dirty_i);
    end
  end

  assign way_o   = way_q;
  assign evict_o = evict_q;
  assign valid_o = valid_q;

endmodule

//--- rtl/llc_tag_store.sv
// Tag store of the last-level cache
// Request control, hit detection, response forming, write-back and BIST hookup
`timescale 1ns/1ps

module llc_tag_store #(
  parameter int unsigned NumWays  = 4,
  parameter int unsigned NumLines = 16,
  parameter int unsigned TagWidth = 8,
  localparam int unsigned IdxW = (NumLines > 1) ? $clog2(NumLines) : 1
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  llc_tag_pkg::mode_e req_mode_i,
  input  logic [IdxW-1:0]    req_index_i,
  input  logic [TagWidth-1:0] req_tag_i,
  input  logic [NumWays-1:0] req_way_i,
  input  logic               req_dirty_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output logic [NumWays-1:0] res_way_o,
  output logic               res_hit_o,
  output logic               res_evict_o,
  output logic [TagWidth-1:0] res_evict_tag_o,
  output logic               res_valid_o,
  input  logic               res_ready_i,
  input  logic [NumWays-1:0] spm_lock_i,
  output logic [NumWays-1:0] bist_res_o,
  output logic               bist_valid_o
);

  localparam int unsigned EntryW = TagWidth + 2;

  // Controller states
  localparam logic [2:0] StIdle = 3'd0;
  localparam logic [2:0] StRead = 3'd1;
  localparam logic [2:0] StLate = 3'd2;
  localparam logic [2:0] StResp = 3'd3;
  localparam logic [2:0] StBist = 3'd4;

  logic [2:0]         state_q, state_d;
  logic               load_req;

  // Held request
  llc_tag_pkg::mode_e req_mode_q;
  logic [IdxW-1:0]    req_index_q;
  logic [TagWidth-1:0] req_tag_q;
  logic [NumWays-1:0] req_way_q;
  logic               req_dirty_q;
  logic               is_flush_q;

  // Memory ports
  logic [NumWays-1:0]             ram_req;
  logic [NumWays-1:0]             ram_we;
  logic [IdxW-1:0]                ram_index;
  logic [EntryW-1:0]              ram_wdata;
  logic [NumWays-1:0][EntryW-1:0] ram_rdata;
  logic [NumWays-1:0]             ram_rvalid;

  // Per-way decode of the read data
  logic [NumWays-1:0] tag_val, tag_dit, tag_equ, hit;
  logic [NumWays-1:0] bist_fail;
  logic               hit_any;
  logic               need_wr;
  logic [EntryW-1:0]  old_entry;

  // Pattern generator
  logic               gen_start, gen_busy, gen_req, gen_we, gen_eoc;
  logic [IdxW-1:0]    gen_index;
  logic [EntryW-1:0]  gen_pattern;

  // Evict box
  logic               evict_req, evict_flag, evict_valid;
  logic [NumWays-1:0] evict_way;

  assign is_flush_q = (req_mode_q == llc_tag_pkg::Flush);
  assign hit_any    = |hit;
  // Hit on a clean line with a dirty request needs a write
  assign need_wr    = req_dirty_q & ~|(hit & tag_dit);

  always_comb begin
    state_d     = state_q;
    req_ready_o = 1'b0;
    load_req    = 1'b0;
    res_valid_o = 1'b0;
    ram_req     = '0;
    ram_we      = '0;
    ram_index   = req_index_q;
    ram_wdata   = '0;
    evict_req   = 1'b0;
    gen_start   = 1'b0;

    case (state_q)
      StIdle: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          load_req = 1'b1;
          if (req_mode_i == llc_tag_pkg::Bist) begin
            gen_start = 1'b1;
            state_d   = StBist;
          end else begin
            // Lookup reads all ways so the victim sees every valid bit
            ram_req   = (req_mode_i == llc_tag_pkg::Flush) ? req_way_i : '1;
            ram_index = req_index_i;
            state_d   = StRead;
          end
        end
      end
      StRead: begin
        if (|ram_rvalid) begin
          if (is_flush_q) begin
            state_d = StLate;
          end else if (hit_any) begin
            res_valid_o = 1'b1;
          end else begin
            evict_req = 1'b1;
            state_d   = StLate;
          end
        end
      end
      // Extra cycle for miss and flush, evict box answers here
      StLate: begin
        res_valid_o = is_flush_q | evict_valid;
      end
      StResp: begin
        res_valid_o = 1'b1;
      end
      StBist: begin
        if (gen_busy) begin
          ram_req   = {NumWays{gen_req}};
          ram_we    = {NumWays{gen_we}};
          ram_index = gen_index;
          ram_wdata = gen_pattern;
        end
        if (gen_eoc) begin
          state_d = StIdle;
        end
      end
      default: begin
        state_d = StIdle;
      end
    endcase

    // Write-back on response acceptance
    if (res_valid_o && res_ready_i) begin
      state_d = StIdle;
      if (is_flush_q) begin
        ram_req = req_way_q;
        ram_we  = req_way_q;
      end else if (hit_any) begin
        if (need_wr) begin
          ram_req   = hit;
          ram_we    = hit;
          ram_wdata = {2'b11, req_tag_q};
        end else if (req_valid_i && (req_mode_i == llc_tag_pkg::Lookup)) begin
          // Clean hit, next lookup starts its read right away
          req_ready_o = 1'b1;
          load_req    = 1'b1;
          ram_req     = '1;
          ram_index   = req_index_i;
          state_d     = StRead;
        end
      end else begin
        // Install the new tag into the victim
        ram_req   = evict_way;
        ram_we    = evict_way;
        ram_wdata = {1'b1, req_dirty_q, req_tag_q};
      end
    end else if (res_valid_o) begin
      state_d = StResp;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_req) begin
      req_mode_q  <= req_mode_i;
      req_index_q <= req_index_i;
      req_tag_q   <= req_tag_i;
      req_way_q   <= req_way_i;
      req_dirty_q <= req_dirty_i;
    end
  end

  for (genvar i = 0; i < NumWays; i++) begin : gen_ways
    llc_tag_sram #(
      .NumLines ( NumLines ),
      .TagWidth ( TagWidth )
    ) i_tag_sram (
      .clk_i    ( clk_i         ),
      .arst_n_i ( arst_n_i      ),
      .req_i    ( ram_req[i]    ),
      .we_i     ( ram_we[i]     ),
      .index_i  ( ram_index     ),
      .wdata_i  ( ram_wdata     ),
      .rdata_o  ( ram_rdata[i]  ),
      .rvalid_o ( ram_rvalid[i] )
    );

    assign tag_val[i]   = ram_rdata[i][EntryW-1];
    assign tag_dit[i]   = ram_rdata[i][EntryW-2];
    assign tag_equ[i]   = (ram_rdata[i][TagWidth-1:0] == req_tag_q);
    // Only searched ways can hit
    assign hit[i]       = req_way_q[i] & tag_val[i] & tag_equ[i];
    // Whole entry against the delayed BIST pattern
    assign bist_fail[i] = (ram_rdata[i] != gen_pattern);
  end

  // Response payload, held with the read data and the evict choice
  always_comb begin
    if (is_flush_q) begin
      res_way_o = req_way_q;
    end else begin
      res_way_o = hit_any ? hit : evict_way;
    end
    old_entry = '0;
    for (int i = 0; i < NumWays; i++) begin
      if (res_way_o[i]) begin
        old_entry = old_entry | ram_rdata[i];
      end
    end
    res_hit_o = ~is_flush_q & hit_any;
    if (is_flush_q) begin
      res_evict_o = old_entry[EntryW-1] & old_entry[EntryW-2];
    end else begin
      res_evict_o = ~hit_any & evict_flag;
    end
    res_evict_tag_o = res_hit_o ? '0 : old_entry[TagWidth-1:0];
  end

  llc_tag_pattern_gen #(
    .NumWays  ( NumWays  ),
    .NumLines ( NumLines ),
    .TagWidth ( TagWidth )
  ) i_pattern_gen (
    .clk_i      ( clk_i       ),
    .arst_n_i   ( arst_n_i    ),
    .start_i    ( gen_start   ),
    .rvalid_i   ( |ram_rvalid ),
    .fail_i     ( bist_fail   ),
    .busy_o     ( gen_busy    ),
    .req_o      ( gen_req     ),
    .we_o       ( gen_we      ),
    .index_o    ( gen_index   ),
    .pattern_o  ( gen_pattern ),
    .bist_res_o ( bist_res_o  ),
    .eoc_o      ( gen_eoc     )
  );

  assign bist_valid_o = gen_eoc;

  llc_evict_box #(
    .NumWays ( NumWays )
  ) i_evict_box (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .req_i       ( evict_req   ),
    .tag_valid_i ( tag_val     ),
    .tag_dirty_i ( tag_dit     ),
    .spm_lock_i  ( spm_lock_i  ),
    .way_o       ( evict_way   ),
    .evict_o     ( evict_flag  ),
    .valid_o     ( evict_valid )
  );

endmodule

//--- sim/tb_clock.sv
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clock #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  // Free running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of rising edges
  // Release lands just after an edge
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule

//--- sim/tb_llc_tag_store.sv
// Testbench of the LLC tag store
// Replays the operation trace and compares every response and self-test result
`timescale 1ns/1ps

module tb_llc_tag_store;

  localparam int unsigned NumWays   = 4;
  localparam int unsigned NumLines  = 16;
  localparam int unsigned TagWidth  = 8;
  localparam int unsigned IdxW      = $clog2(NumLines);
  localparam int          WaitLimit = 200;

  logic                clk_i;
  logic                arst_n_i;
  llc_tag_pkg::mode_e  req_mode_i;
  logic [IdxW-1:0]     req_index_i;
  logic [TagWidth-1:0] req_tag_i;
  logic [NumWays-1:0]  req_way_i;
  logic                req_dirty_i;
  logic                req_valid_i;
  logic                req_ready_o;
  logic [NumWays-1:0]  res_way_o;
  logic                res_hit_o;
  logic                res_evict_o;
  logic [TagWidth-1:0] res_evict_tag_o;
  logic                res_valid_o;
  logic                res_ready_i;
  logic [NumWays-1:0]  spm_lock_i;
  logic [NumWays-1:0]  bist_res_o;
  logic                bist_valid_o;

  int error_count;
  int timeout_count;
  int op_count;
  int line_no;

  tb_clock #(
    .PeriodNs    ( 8  ),
    .ResetCycles ( 10 )
  ) i_clk (
    .clk_o    ( clk_i    ),
    .arst_n_o ( arst_n_i )
  );

  llc_tag_store #(
    .NumWays  ( NumWays  ),
    .NumLines ( NumLines ),
    .TagWidth ( TagWidth )
  ) i_dut (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .req_mode_i      ( req_mode_i      ),
    .req_index_i     ( req_index_i     ),
    .req_tag_i       ( req_tag_i       ),
    .req_way_i       ( req_way_i       ),
    .req_dirty_i     ( req_dirty_i     ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_o     ( req_ready_o     ),
    .res_way_o       ( res_way_o       ),
    .res_hit_o       ( res_hit_o       ),
    .res_evict_o     ( res_evict_o     ),
    .res_evict_tag_o ( res_evict_tag_o ),
    .res_valid_o     ( res_valid_o     ),
    .res_ready_i     ( res_ready_i     ),
    .spm_lock_i      ( spm_lock_i      ),
    .bist_res_o      ( bist_res_o      ),
    .bist_valid_o    ( bist_valid_o    )
  );

  // One-hot way vectors
  task automatic check_way(input string name, input logic [NumWays-1:0] got,
                           input logic [NumWays-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] trace line %0d: %s = 0x%h, expected 0x%h", line_no, name, got, exp);
      error_count++;
    end
  endtask

  // Single bit flags such as hit, evict and the handshakes
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] trace line %0d: %s = 0x%h, expected 0x%h", line_no, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_tag(input string name, input logic [TagWidth-1:0] got,
                           input logic [TagWidth-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] trace line %0d: %s = 0x%h, expected 0x%h", line_no, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bist(input logic [NumWays-1:0] got, input logic [NumWays-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] trace line %0d: bist_res_o = 0x%h, expected 0x%h", line_no, got, exp);
      error_count++;
    end
  endtask

  // Response payload against the trace
  task automatic check_response(input logic [NumWays-1:0] exp_way, input logic exp_hit,
                                input logic exp_evict, input logic [TagWidth-1:0] exp_tag);
    check_way("res_way_o", res_way_o, exp_way);
    check_flag("res_hit_o", res_hit_o, exp_hit);
    check_flag("res_evict_o", res_evict_o, exp_evict);
    // Old tag only means something on a write-back
    if (exp_evict) begin
      check_tag("res_evict_tag_o", res_evict_tag_o, exp_tag);
    end
  endtask

  // Valid stays up until ready was seen before a rising edge
  task automatic send_request(output bit ok);
    bit seen;
    seen        = 1'b0;
    ok          = 1'b0;
    req_valid_i = 1'b1;
    for (int cyc = 0; cyc < WaitLimit && !ok; cyc++) begin
      @(negedge clk_i);
      seen = req_ready_o;
      @(posedge clk_i);
      ok = seen;
    end
    #1;
    req_valid_i = 1'b0;
    if (!ok) begin
      $display("Timed out waiting for the DUT to take the request of trace line %0d", line_no);
      timeout_count++;
    end
  endtask

  // Returns on the falling edge of the first cycle with a response
  task automatic wait_response(output bit ok);
    ok = 1'b0;
    for (int cyc = 0; cyc < WaitLimit && !ok; cyc++) begin
      @(negedge clk_i);
      ok = res_valid_o;
    end
    if (!ok) begin
      $display("Timed out waiting for the response to trace line %0d", line_no);
      timeout_count++;
    end
  endtask

  task automatic wait_bist(output bit ok);
    ok = 1'b0;
    for (int cyc = 0; cyc < WaitLimit && !ok; cyc++) begin
      @(negedge clk_i);
      ok = bist_valid_o;
    end
    if (!ok) begin
      $display("Timed out waiting for the self test end of trace line %0d", line_no);
      timeout_count++;
    end
  endtask

  // Response must hold under a stalled ready with no new request taken
  task automatic accept_response(input int stall, input logic [NumWays-1:0] exp_way,
                                 input logic exp_hit, input logic exp_evict,
                                 input logic [TagWidth-1:0] exp_tag);
    for (int k = 0; k < stall; k++) begin
      @(negedge clk_i);
      check_flag("res_valid_o", res_valid_o, 1'b1);
      check_flag("req_ready_o", req_ready_o, 1'b0);
      check_response(exp_way, exp_hit, exp_evict, exp_tag);
    end
    @(posedge clk_i);
    #1;
    res_ready_i = 1'b1;
    // Write-back happens on the acceptance edge
    @(posedge clk_i);
    #1;
    res_ready_i = 1'b0;
    // One response per request
    check_flag("res_valid_o", res_valid_o, 1'b0);
  endtask

  initial begin
    bit          ok;
    bit          abort;
    bit          rst_done;
    int          fd;
    int          n;
    string       line;
    byte         first;
    logic [31:0] f_mode, f_index, f_tag, f_ways, f_dirty, f_lock, f_stall;
    logic [31:0] e_way, e_hit, e_evict, e_tag, e_bist;

    req_mode_i    = llc_tag_pkg::Lookup;
    req_index_i   = '0;
    req_tag_i     = '0;
    req_way_i     = '0;
    req_dirty_i   = 1'b0;
    req_valid_i   = 1'b0;
    res_ready_i   = 1'b0;
    spm_lock_i    = '0;
    error_count   = 0;
    timeout_count = 0;
    op_count      = 0;
    line_no       = 0;
    abort         = 1'b0;
    rst_done      = 1'b0;
    fd            = 0;

    for (int cyc = 0; cyc < WaitLimit && !rst_done; cyc++) begin
      @(posedge clk_i);
      rst_done = arst_n_i;
    end
    #1;
    if (!rst_done) begin
      $display("Timed out waiting for the reset to be released");
      timeout_count++;
      abort = 1'b1;
    end else begin
      // Idle outputs straight after reset
      check_flag("req_ready_o", req_ready_o, 1'b1);
      check_flag("res_valid_o", res_valid_o, 1'b0);
      check_flag("bist_valid_o", bist_valid_o, 1'b0);
      fd = $fopen("sim/llc_tag_trace.txt", "r");
      if (fd == 0) begin
        $display("The trace file sim/llc_tag_trace.txt could not be opened");
        error_count++;
        abort = 1'b1;
      end
    end

    while (!abort && $fgets(line, fd) != 0) begin
      line_no++;
      first = line.getc(0);
      // Comment and empty lines carry no operation
      if (line.len() > 1 && first != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f_mode, f_index, f_tag,
                    f_ways, f_dirty, f_lock, f_stall, e_way, e_hit, e_evict, e_tag, e_bist);
        if (n != 12) begin
          $display("Trace line %0d does not hold twelve fields", line_no);
          error_count++;
        end else begin
          op_count++;
          req_mode_i  = llc_tag_pkg::mode_e'(f_mode[1:0]);
          req_index_i = f_index[IdxW-1:0];
          req_tag_i   = f_tag[TagWidth-1:0];
          req_way_i   = f_ways[NumWays-1:0];
          req_dirty_i = f_dirty[0];
          spm_lock_i  = f_lock[NumWays-1:0];
          send_request(ok);
          if (ok && req_mode_i == llc_tag_pkg::Bist) begin
            // Self test answers only with the result pulse
            wait_bist(ok);
            if (ok) begin
              check_bist(bist_res_o, e_bist[NumWays-1:0]);
              @(posedge clk_i);
              #1;
              // Result is a single cycle pulse
              check_flag("bist_valid_o", bist_valid_o, 1'b0);
            end
          end else if (ok) begin
            wait_response(ok);
            if (ok) begin
              check_response(e_way[NumWays-1:0], e_hit[0], e_evict[0],
                             e_tag[TagWidth-1:0]);
              accept_response(int'(f_stall), e_way[NumWays-1:0], e_hit[0], e_evict[0],
                              e_tag[TagWidth-1:0]);
            end
          end
          abort = !ok;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (!abort && op_count == 0) begin
      $display("The trace held no operation");
      error_count++;
    end

    $display("Operations %0d, errors %0d, timeouts %0d", op_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- sim/llc_tag_trace.txt
# Columns: mode index tag ways dirty lock stall, then expected way hit evict evict_tag bist_res
# Modes 0 lookup, 1 flush, 2 bist; all fields hex; evict_tag is checked only when evict is 1
# Self test, then misses into way 0 of the cleared store
2 0 00 0 0 0 0  0 0 0 00 0
0 3 a5 f 0 0 0  1 0 0 00 0
0 5 3c f 1 0 0  1 0 0 00 0
# Hits, a dirty hit, then set 3 fills up
0 3 a5 f 0 0 0  1 1 0 00 0
0 3 a5 f 1 0 1  1 1 0 00 0
0 3 11 f 0 0 0  2 0 0 00 0
0 3 22 f 1 0 0  4 0 0 00 0
0 3 33 f 0 0 0  8 0 0 00 0
0 3 44 f 0 0 0  1 0 1 a5 0
# Round robin over a full set with locked ways skipped
0 3 55 f 0 2 0  4 0 1 22 0
0 3 66 f 1 9 0  2 0 0 00 0
0 3 77 f 0 0 0  4 0 0 00 0
0 3 88 f 0 8 0  1 0 0 00 0
0 3 99 f 0 0 3  2 0 1 66 0
0 7 c1 f 1 1 0  2 0 0 00 0
# Flushes, dirty then clean, and a miss on the flushed tag
1 7 00 2 0 0 0  2 0 1 c1 0
1 7 00 2 0 0 0  2 0 0 00 0
0 7 c1 f 0 0 0  1 0 0 00 0
1 3 00 4 0 0 2  4 0 0 00 0
1 5 00 1 0 0 1  1 0 1 3c 0
# Partial search, free way fill, full set again
0 3 99 2 0 0 2  2 1 0 00 0
0 3 be f 1 0 0  4 0 0 00 0
0 3 33 f 0 0 0  8 1 0 00 0
0 3 12 f 0 0 0  4 0 1 be 0
# Second self test clears every line
2 0 00 0 0 0 0  0 0 0 00 0
0 3 88 f 0 0 0  1 0 0 00 0
0 f f0 f 1 0 0  1 0 0 00 0
0 f f0 f 0 0 0  1 1 0 00 0
0 3 88 e 0 0 0  2 0 0 00 0
1 3 00 2 0 0 0  2 0 0 00 0

//--- all.f
rtl/llc_tag_pkg.sv
rtl/llc_tag_sram.sv
rtl/llc_tag_pattern_gen.sv
rtl/llc_evict_box.sv
rtl/llc_tag_store.sv
sim/tb_clock.sv
sim/tb_llc_tag_store.sv

//--- run.sh
#!/bin/sh
# Build and run the tag store testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_llc_tag_store -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_llc_tag_store)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^All tests passed$"; then
  exit 0
fi
exit 1
